/* cycleAck_defines.svh */
// Timing and address map constants for the bus-cycle termination logic
// Include in any module that needs the ROM delay, timeout or window values
`ifndef CYCLE_ACK_DEFINES_SVH
`define CYCLE_ACK_DEFINES_SVH

// Clock edges from ts sampling to the ROM acknowledge
`define ROM_WAIT_CYCLES 3
// Clock edges from ts sampling to the bus timeout acknowledge
`define BUS_TIMEOUT_CYCLES 32

// ROM window, compared on address bits 31:19
`define ROM_BASE 13'h001F
`define ROM_MASK 13'h1FFF
// CIA window, compared on address bits 31:16
`define CIA_BASE 16'h00BF
`define CIA_MASK 16'hFFFF
// Everything below this address is RAM
`define RAM_LIMIT 32'h0020_0000

`endif

/* cycleAckPkg.sv */
// Types shared by the bus-cycle termination blocks and their testbench
// Modules pull these in with a wildcard import in the module header
`default_nettype none

package cycleAckPkg;

    // CPU address as seen on the 68040 bus
    typedef logic [31:0] busAddrT;

    // Wait counter width used by the ROM delay and the bus timeout
    typedef logic [5:0] waitCountT;

    // Class of the cycle in flight, held from ts until the acknowledge
    typedef enum logic [2:0] {
        SPACE_IDLE,
        SPACE_ROM,
        SPACE_CIA,
        SPACE_RAM,
        SPACE_UNMAPPED
    } spaceT;

    // The CIA responder first waits for the clock high, then for it low
    typedef enum logic {
        CIA_WAIT_HIGH,
        CIA_WAIT_LOW
    } ciaSyncStateT;

endpackage

`default_nettype wire

/* addressDecoder.sv */
// Address decoder for the bus-cycle termination logic
// Samples addr on ts and holds the space class until the cycle is acknowledged
`timescale 1ns/1ps
`default_nettype none

`include "cycleAck_defines.svh"

module addressDecoder import cycleAckPkg::*; (
    input  wire logic    CLK40,
    input  wire logic    nRESET,
    input  wire logic    ts,
    input  wire busAddrT addr,
    input  wire logic    cycleDone,
    output spaceT        space
);

    ////////////////////////////////////////
    // Window compare
    ////////////////////////////////////////

    // Classify one address against the windows from the defines header
    // ROM and CIA are checked ahead of RAM so a window overlap never lands in RAM
    function automatic spaceT decodeSpace(input busAddrT a);
        spaceT result;
        if ((a[31:19] & `ROM_MASK) == `ROM_BASE) begin
            result = SPACE_ROM;
        end else if ((a[31:16] & `CIA_MASK) == `CIA_BASE) begin
            result = SPACE_CIA;
        end else if (a < `RAM_LIMIT) begin
            result = SPACE_RAM;
        end else begin
            result = SPACE_UNMAPPED;
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Held cycle class
    ////////////////////////////////////////

    // A new cycle is taken from idle, and also from RAM space
    // RAM cycles are ended by the external RAM controller, so no
    // cycleDone ever arrives for them and the next ts must release them
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            space <= SPACE_IDLE;
        end else if (cycleDone) begin
            space <= SPACE_IDLE;
        end else if (ts && (space == SPACE_IDLE || space == SPACE_RAM)) begin
            space <= decodeSpace(addr);
        end
    end

endmodule

`default_nettype wire

/* romAckDelay.sv */
// ROM responder for the bus-cycle termination logic
// Delays the transfer acknowledge of a ROM cycle to meet the ROM setup time
// and drives the active-low ROM enable for the length of the cycle
`timescale 1ns/1ps
`default_nettype none

`include "cycleAck_defines.svh"

module romAckDelay import cycleAckPkg::*; (
    input  wire logic  CLK40,
    input  wire logic  nRESET,
    input  wire logic  ts,
    input  wire spaceT space,
    output logic       romAck,
    output logic       nRomEn
);

    // Counter value at which the acknowledge is registered
    // The count starts at zero on the edge that samples ts
    localparam waitCountT ROM_ACK_COUNT = waitCountT'(`ROM_WAIT_CYCLES - 1);

    waitCountT romCount;
    logic      romCycle;

    assign romCycle = (space == SPACE_ROM);

    // The held space is already a register, so the enable follows it directly
    assign nRomEn = ~romCycle;

    ////////////////////////////////////////
    // Setup delay counter
    ////////////////////////////////////////

    // Start at zero on ts, count while the cycle stays in ROM space
    // The count parks at the top so it cannot wrap and fire twice
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            romCount <= '0;
            romAck   <= 1'b0;
        end else begin
            if (ts || !romCycle) begin
                romCount <= '0;
            end else if (romCount != '1) begin
                romCount <= romCount + 1'b1;
            end
            // Single-cycle strobe, high during the cycle after edge ROM_WAIT_CYCLES
            romAck <= romCycle && !ts && (romCount == ROM_ACK_COUNT);
        end
    end

endmodule

`default_nettype wire

/* ciaAckSync.sv */
// CIA responder for the bus-cycle termination logic
// Synchronizes the slow CIA clock and acknowledges a CIA cycle only after
// a high-to-low transition of that clock seen during the cycle
`timescale 1ns/1ps
`default_nettype none

module ciaAckSync import cycleAckPkg::*; (
    input  wire logic  CLK40,
    input  wire logic  nRESET,
    input  wire logic  ciaClk,
    input  wire spaceT space,
    input  wire logic  cycleDone,
    output logic       ciaAck
);

    // Two-flop history of the CIA clock, bit 1 is the older sample
    logic [1:0]   ciaHist;
    ciaSyncStateT ciaState;
    logic         ciaCycle;

    assign ciaCycle = (space == SPACE_CIA);

    ////////////////////////////////////////
    // CIA clock synchronizer
    ////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            ciaHist <= 2'b00;
        end else begin
            ciaHist <= {ciaHist[0], ciaClk};
        end
    end

    ////////////////////////////////////////
    // Edge qualifier FSM
    ////////////////////////////////////////

    // The peripheral may only be released at or after a falling CIA clock edge
    // with its chip select active, so a high level has to be seen first
    // inside the cycle before a low level counts
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            ciaState <= CIA_WAIT_HIGH;
            ciaAck   <= 1'b0;
        end else begin
            ciaAck <= 1'b0;
            if (cycleDone || !ciaCycle) begin
                ciaState <= CIA_WAIT_HIGH;
            end else begin
                case (ciaState)
                    CIA_WAIT_HIGH: begin
                        if (ciaHist == 2'b11) begin
                            ciaState <= CIA_WAIT_LOW;
                        end
                    end
                    CIA_WAIT_LOW: begin
                        // Low on both samples, so the falling edge is real
                        if (ciaHist == 2'b00) begin
                            ciaAck   <= 1'b1;
                            ciaState <= CIA_WAIT_HIGH;
                        end
                    end
                    default: ciaState <= CIA_WAIT_HIGH;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* busTimeout.sv */
// Bus timeout responder for the bus-cycle termination logic
// Ends an access to unmapped space after a fixed number of clocks
// so the CPU never waits forever for an acknowledge
`timescale 1ns/1ps
`default_nettype none

`include "cycleAck_defines.svh"

module busTimeout import cycleAckPkg::*; (
    input  wire logic  CLK40,
    input  wire logic  nRESET,
    input  wire spaceT space,
    input  wire logic  cycleDone,
    output logic       timeoutAck
);

    // The count is zero on the first edge after ts sampling,
    // which puts the strobe after edge BUS_TIMEOUT_CYCLES
    localparam waitCountT TIMEOUT_COUNT = waitCountT'(`BUS_TIMEOUT_CYCLES - 1);

    waitCountT timeoutCount;
    logic      unmappedCycle;

    assign unmappedCycle = (space == SPACE_UNMAPPED);

    ////////////////////////////////////////
    // Timeout counter
    ////////////////////////////////////////

    // Any change away from unmapped space restarts the count from zero
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            timeoutCount <= '0;
            timeoutAck   <= 1'b0;
        end else begin
            if (cycleDone || !unmappedCycle) begin
                timeoutCount <= '0;
            end else if (timeoutCount != '1) begin
                timeoutCount <= timeoutCount + 1'b1;
            end
            // One strobe per access, none once the cycle is already ending
            timeoutAck <= unmappedCycle && !cycleDone && (timeoutCount == TIMEOUT_COUNT);
        end
    end

endmodule

`default_nettype wire

/* transferAckMerge.sv */
// Transfer acknowledge merge for the bus-cycle termination logic
// Combines the responder strobes into nTa and nTci with their output enables
// The board pads tristate each pin from its enable
`timescale 1ns/1ps
`default_nettype none

module transferAckMerge import cycleAckPkg::*; (
    input  wire logic  CLK40,
    input  wire logic  nRESET,
    input  wire spaceT space,
    input  wire logic  romAck,
    input  wire logic  ciaAck,
    input  wire logic  timeoutAck,
    output logic       nTa,
    output logic       taEn,
    output logic       nTci,
    output logic       tciEn,
    output logic       cycleDone
);

    logic anyAck;
    logic ackSpace;
    logic ciaCycle;
    // High for the one cycle after an acknowledge, when nTa is driven high
    logic driveHigh;
    // Marks that the acknowledge just given ended a CIA cycle
    logic ciaDone;

    ////////////////////////////////////////
    // Acknowledge and enables
    ////////////////////////////////////////

    // Only one responder is armed per cycle, so a plain OR is enough
    assign anyAck    = romAck | ciaAck | timeoutAck;
    assign cycleDone = anyAck;

    // RAM space is left alone, its controller owns nTa
    assign ackSpace = (space == SPACE_ROM) || (space == SPACE_CIA) ||
                      (space == SPACE_UNMAPPED);
    assign ciaCycle = (space == SPACE_CIA);

    assign nTa  = ~anyAck;
    assign taEn = ackSpace | driveHigh;

    // CIA space is not cacheable, so nTci follows nTa there
    assign nTci  = ciaCycle ? ~anyAck : 1'b1;
    assign tciEn = ciaCycle | ciaDone;

    ////////////////////////////////////////
    // Drive-high cycle
    ////////////////////////////////////////

    // Holding the pins high one more cycle stops a slow rise from
    // ending the next cycle early
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            driveHigh <= 1'b0;
            ciaDone   <= 1'b0;
        end else begin
            driveHigh <= anyAck && ackSpace;
            ciaDone   <= anyAck && ciaCycle;
        end
    end

endmodule

`default_nettype wire

/* cycleAckTop.sv */
// Top level of the 68040 bus-cycle termination logic
// Decoder feeds the ROM, CIA and timeout responders, whose strobes are merged
// into the transfer acknowledge and cache-inhibit pins with their enables
`timescale 1ns/1ps
`default_nettype none

module cycleAckTop import cycleAckPkg::*; (
    input  wire logic    CLK40,
    input  wire logic    nRESET,
    input  wire logic    ts,
    input  wire busAddrT addr,
    input  wire logic    ciaClk,
    output logic         nTa,
    output logic         taEn,
    output logic         nTci,
    output logic         tciEn,
    output logic         nRomEn
);

    spaceT space;
    logic  cycleDone;
    logic  romAck;
    logic  ciaAck;
    logic  timeoutAck;

    ////////////////////////////////////////
    // Cycle class
    ////////////////////////////////////////

    addressDecoder u_addressDecoder (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .ts        (ts),
        .addr      (addr),
        .cycleDone (cycleDone),
        .space     (space)
    );

    ////////////////////////////////////////
    // Responders
    ////////////////////////////////////////

    romAckDelay u_romAckDelay (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .ts     (ts),
        .space  (space),
        .romAck (romAck),
        .nRomEn (nRomEn)
    );

    ciaAckSync u_ciaAckSync (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .ciaClk    (ciaClk),
        .space     (space),
        .cycleDone (cycleDone),
        .ciaAck    (ciaAck)
    );

    busTimeout u_busTimeout (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .space      (space),
        .cycleDone  (cycleDone),
        .timeoutAck (timeoutAck)
    );

    // Pin outputs and the cycleDone strobe back to the decoder
    transferAckMerge u_transferAckMerge (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .space      (space),
        .romAck     (romAck),
        .ciaAck     (ciaAck),
        .timeoutAck (timeoutAck),
        .nTa        (nTa),
        .taEn       (taEn),
        .nTci       (nTci),
        .tciEn      (tciEn),
        .cycleDone  (cycleDone)
    );

endmodule

`default_nettype wire

/* cycleAckTb.sv */
// Directed testbench for the 68040 bus-cycle termination logic
// Runs ROM, CIA, unmapped and RAM cycles through cycleAckTop and checks
// nTa, nTci, their enables and nRomEn against the expected cycle timing
`timescale 1ns/1ps
`default_nettype none

`include "cycleAck_defines.svh"

module cycleAckTb import cycleAckPkg::*; ();

    logic    CLK40;
    logic    nRESET;
    logic    ts;
    busAddrT addr;
    logic    ciaClk;
    logic    nTa;
    logic    taEn;
    logic    nTci;
    logic    tciEn;
    logic    nRomEn;

    // Time of the last CIA clock fall and of the edge that sampled ts
    time         lastCiaFall;
    time         tsEdgeTime;
    int unsigned seedValue;

    cycleAckTop dut (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .ts     (ts),
        .addr   (addr),
        .ciaClk (ciaClk),
        .nTa    (nTa),
        .taEn   (taEn),
        .nTci   (nTci),
        .tciEn  (tciEn),
        .nRomEn (nRomEn)
    );

    ////////////////////////////////////////
    // Clocks
    ////////////////////////////////////////

    always #5 CLK40 = ~CLK40;

    // 400 ns CIA clock, its edges fall 3 ns off the CLK40 grid
    always begin
        #197;
        ciaClk      = 1'b1;
        #200;
        ciaClk      = 1'b0;
        lastCiaFall = $time;
        #3;
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %b, expected %b", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkCycles(input string name, input waitCountT actual,
                               input waitCountT expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %0d, expected %0d", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout at %0t: %s never arrived", $time, what);
        $display("tests failed");
        $fatal(1, "timeout");
    endtask

    ////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////

    // Pulses ts for one cycle and returns at the negedge after the sampling edge
    task automatic startCycle(input busAddrT a);
        @(posedge CLK40);
        ts   <= 1'b1;
        addr <= a;
        @(posedge CLK40);
        ts         <= 1'b0;
        tsEdgeTime = $time;
        @(negedge CLK40);
    endtask

    // Counts edges after ts sampling until nTa is seen low, at most limit edges
    task automatic waitForAck(input int limit, input string what, output int edges);
        edges = 0;
        while (nTa !== 1'b0 && edges < limit) begin
            @(negedge CLK40);
            edges++;
        end
        if (nTa !== 1'b0) begin
            timeoutFail(what);
        end
    endtask

    task automatic idleGap();
        int n;
        n = $urandom % 4;
        repeat (n + 1) @(negedge CLK40);
    endtask

    // After the acknowledge cycle nTa is driven high once, then released
    task automatic checkDriveHigh();
        @(negedge CLK40);
        checkBit("nTa", nTa, 1'b1);
        checkBit("taEn", taEn, 1'b1);
        @(negedge CLK40);
        checkBit("taEn", taEn, 1'b0);
        checkBit("tciEn", tciEn, 1'b0);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic resetTest();
        @(negedge CLK40);
        checkBit("nTa", nTa, 1'b1);
        checkBit("nTci", nTci, 1'b1);
        checkBit("nRomEn", nRomEn, 1'b1);
        checkBit("taEn", taEn, 1'b0);
        checkBit("tciEn", tciEn, 1'b0);
    endtask

    task automatic romCycleTest(input int count);
        busAddrT r;
        int      edges;
        for (int i = 0; i < count; i++) begin
            r = $urandom;
            startCycle({`ROM_BASE, r[18:0]});
            checkBit("nRomEn", nRomEn, 1'b0);
            waitForAck(`ROM_WAIT_CYCLES + 8, "ROM acknowledge", edges);
            checkCycles("romLatency", waitCountT'(edges), waitCountT'(`ROM_WAIT_CYCLES));
            checkBit("taEn", taEn, 1'b1);
            checkBit("tciEn", tciEn, 1'b0);
            checkBit("nTci", nTci, 1'b1);
            @(negedge CLK40);
            checkBit("nTa", nTa, 1'b1);
            checkBit("taEn", taEn, 1'b1);
            checkBit("nRomEn", nRomEn, 1'b1);
            @(negedge CLK40);
            checkBit("taEn", taEn, 1'b0);
            idleGap();
        end
    endtask

    task automatic ciaCycleTest(input int count);
        busAddrT r;
        int      edges;
        for (int i = 0; i < count; i++) begin
            r = $urandom;
            startCycle({`CIA_BASE, r[15:0]});
            // Two CIA periods are 80 CLK40 cycles
            waitForAck(80, "CIA acknowledge within two CIA periods", edges);
            checkBit("nTci", nTci, 1'b0);
            checkBit("tciEn", tciEn, 1'b1);
            checkBit("taEn", taEn, 1'b1);
            // The acknowledge has to follow a falling CIA edge inside this cycle
            checkBit("ciaClk", ciaClk, 1'b0);
            checkBit("ciaFallAfterTs", lastCiaFall > tsEdgeTime, 1'b1);
            checkBit("ciaLowTwoEdges", ($time - lastCiaFall) >= 20, 1'b1);
            @(negedge CLK40);
            checkBit("nTa", nTa, 1'b1);
            checkBit("nTci", nTci, 1'b1);
            checkBit("tciEn", tciEn, 1'b1);
            checkBit("taEn", taEn, 1'b1);
            @(negedge CLK40);
            checkBit("taEn", taEn, 1'b0);
            checkBit("tciEn", tciEn, 1'b0);
            idleGap();
        end
    endtask

    task automatic unmappedCycleTest(input int count);
        busAddrT r;
        int      edges;
        for (int i = 0; i < count; i++) begin
            // Top two bits 01 keep the address clear of ROM, CIA and RAM
            r = $urandom;
            startCycle({2'b01, r[29:0]});
            waitForAck(`BUS_TIMEOUT_CYCLES + 8, "bus timeout acknowledge", edges);
            checkCycles("timeoutLatency", waitCountT'(edges),
                        waitCountT'(`BUS_TIMEOUT_CYCLES));
            checkBit("tciEn", tciEn, 1'b0);
            checkBit("taEn", taEn, 1'b1);
            checkDriveHigh();
            idleGap();
        end
    endtask

    // RAM is ended by the outside controller, so this block stays silent
    task automatic ramCycleTest(input int count);
        busAddrT r;
        for (int i = 0; i < count; i++) begin
            r = $urandom;
            startCycle(r % `RAM_LIMIT);
            repeat (64) begin
                checkBit("taEn", taEn, 1'b0);
                checkBit("tciEn", tciEn, 1'b0);
                checkBit("nTa", nTa, 1'b1);
                @(negedge CLK40);
            end
            // A following ROM cycle shows the RAM class was released
            romCycleTest(1);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        CLK40       = 1'b0;
        ciaClk      = 1'b0;
        nRESET      = 1'b0;
        ts          = 1'b0;
        addr        = '0;
        lastCiaFall = 0;
        tsEdgeTime  = 0;
        seedValue   = $urandom(10);

        repeat (3) @(posedge CLK40);
        nRESET <= 1'b1;

        resetTest();
        romCycleTest(4);
        ciaCycleTest(4);
        unmappedCycleTest(2);
        ramCycleTest(2);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
cycleAckPkg.sv
addressDecoder.sv
romAckDelay.sv
ciaAckSync.sv
busTimeout.sv
transferAckMerge.sv
cycleAckTop.sv
cycleAckTb.sv

/* Bender.yml */
package:
  name: cycle_ack

sources:
  # RTL of the bus-cycle termination logic, package first
  - include_dirs:
      - .
    files:
      - cycleAckPkg.sv
      - addressDecoder.sv
      - romAckDelay.sv
      - ciaAckSync.sv
      - busTimeout.sv
      - transferAckMerge.sv
      - cycleAckTop.sv

  # Directed testbench
  - target: test
    include_dirs:
      - .
    files:
      - cycleAckTb.sv
